/* common/pix_pkg.sv */
package pix_pkg;

    // ====================
    // Word widths
    // ====================

    // Raw sensor pixel
    typedef logic [11:0] pix_t;

    // Stored and read-out word
    typedef logic [15:0] word_t;

    // Block index in the block store, 8 blocks
    typedef logic [2:0] block_t;

    // ====================
    // Commands
    // ====================

    typedef enum logic {
        cmd_capture = 1'b0,
        cmd_readout = 1'b1
    } cmd_e;

    // ====================
    // Bundles
    // ====================

    // One sampled cycle of the parallel pixel port
    typedef struct packed {
        logic fv;
        logic lv;
        pix_t d;
    } pix_bus_t;

    // Block command to the block store
    typedef struct packed {
        block_t block;
        logic   write;
    } ram_cmd_t;

endpackage

/* verilog/toggle_sync.sv */
module toggle_sync (
    input  logic clk,
    input  logic arst_n,
    input  logic toggle_in,
    output logic pulse
);

    logic sync_1;
    logic sync_2;
    logic sync_3;

    // Two flops for metastability, the third remembers the last level
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            sync_3 <= 1'b0;
        end else begin
            sync_1 <= toggle_in;
            sync_2 <= sync_1;
            sync_3 <= sync_2;
        end
    end

    // One cycle per edge of the toggle
    assign pulse = sync_2 ^ sync_3;

endmodule

/* bank_fifo/bank_fifo.sv */
module bank_fifo #(
    parameter int width      = 16,
    parameter int depth_log2 = 3
) (
    // Write side
    input  logic           w_clk,
    input  logic           w_arst_n,
    input  logic           w_trigger,
    input  pix_pkg::word_t w_data,

    // Read side
    input  logic           r_clk,
    input  logic           r_arst_n,
    output logic           r_ready,
    input  logic           r_trigger,
    output pix_pkg::word_t r_data
);

    localparam int depth = 2 ** depth_log2;

    // One extra bit to tell full from empty
    typedef logic [depth_log2:0] ptr_t;

    // Full when the two top Gray bits differ and the rest match
    localparam ptr_t full_mask = ptr_t'(2'b11) << (depth_log2 - 1);

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    logic [width-1:0] mem [depth];

    ptr_t w_bin;
    ptr_t w_gray;
    ptr_t w_bin_next;
    ptr_t r_gray_w1;
    ptr_t r_gray_w2;
    logic w_full;
    logic w_en;

    ptr_t r_bin;
    ptr_t r_gray;
    ptr_t r_bin_next;
    ptr_t w_gray_r1;
    ptr_t w_gray_r2;

    // ====================
    // Write domain
    // ====================

    assign w_full     = (w_gray == (r_gray_w2 ^ full_mask));
    // A word arriving on a full FIFO is dropped
    assign w_en       = w_trigger && !w_full;
    assign w_bin_next = w_bin + ptr_t'(1);

    always_ff @(posedge w_clk or negedge w_arst_n) begin
        if (!w_arst_n) begin
            w_bin     <= '0;
            w_gray    <= '0;
            r_gray_w1 <= '0;
            r_gray_w2 <= '0;
        end else begin
            r_gray_w1 <= r_gray;
            r_gray_w2 <= r_gray_w1;
            if (w_en) begin
                w_bin  <= w_bin_next;
                w_gray <= bin2gray(w_bin_next);
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_en) begin
            mem[w_bin[depth_log2-1:0]] <= w_data;
        end
    end

    // ====================
    // Read domain
    // ====================

    // First word falls through, valid while the pointers differ
    assign r_ready    = (r_gray != w_gray_r2);
    assign r_data     = mem[r_bin[depth_log2-1:0]];
    assign r_bin_next = r_bin + ptr_t'(1);

    always_ff @(posedge r_clk or negedge r_arst_n) begin
        if (!r_arst_n) begin
            r_bin     <= '0;
            r_gray    <= '0;
            w_gray_r1 <= '0;
            w_gray_r2 <= '0;
        end else begin
            w_gray_r1 <= w_gray;
            w_gray_r2 <= w_gray_r1;
            if (r_ready && r_trigger) begin
                r_bin  <= r_bin_next;
                r_gray <= bin2gray(r_bin_next);
            end
        end
    end

endmodule

/* verilog/pix_capture.sv */
module pix_capture (
    input  logic              pix_dclk,
    input  logic              arst_n,
    input  pix_pkg::pix_bus_t pix,
    input  logic              cap_toggle,
    output logic              fifo_wr,
    output pix_pkg::word_t    fifo_wdata
);

    import pix_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_frame_end,
        wait_frame_start,
        in_frame
    } state_t;

    state_t   state;
    pix_bus_t pix_q;
    logic     cap_pulse;

    // Capture request from the system clock
    toggle_sync cap_sync0 (
        .clk       (pix_dclk),
        .arst_n    (arst_n),
        .toggle_in (cap_toggle),
        .pulse     (cap_pulse)
    );

    always_ff @(posedge pix_dclk or negedge arst_n) begin
        if (!arst_n) begin
            pix_q   <= '0;
            state   <= idle;
            fifo_wr <= 1'b0;
        end else begin
            pix_q <= pix;
            // The rising fv cycle of wait_frame_start already counts
            fifo_wr <= pix_q.fv && pix_q.lv &&
                       (state == wait_frame_start || state == in_frame);

            case (state)
                idle: begin
                    if (cap_pulse) begin
                        state <= wait_frame_end;
                    end
                end
                // Skip a frame that is already running
                wait_frame_end: begin
                    if (!pix_q.fv) begin
                        state <= wait_frame_start;
                    end
                end
                wait_frame_start: begin
                    if (pix_q.fv) begin
                        state <= in_frame;
                    end
                end
                in_frame: begin
                    if (!pix_q.fv) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Zero-extended pixel
    always_ff @(posedge pix_dclk) begin
        fifo_wdata <= {{($bits(word_t) - $bits(pix_t)){1'b0}}, pix_q.d};
    end

endmodule

/* ram_ctrl/ram_ctrl.sv */
module ram_ctrl #(
    parameter int block_size = 64,
    parameter int n_blocks   = 8
) (
    input  logic              clk,
    input  logic              arst_n,

    // Block command
    input  pix_pkg::ram_cmd_t cmd,
    input  logic              cmd_trigger,
    output logic              cmd_ready,

    // Write stream
    input  logic              wr_trigger,
    input  pix_pkg::word_t    wr_data,
    output logic              wr_ready,

    // Read stream
    input  logic              rd_trigger,
    output logic              rd_ready,
    output pix_pkg::word_t    rd_data
);

    import pix_pkg::*;

    localparam int addr_w = $clog2(n_blocks * block_size);

    typedef logic [addr_w-1:0] addr_t;

    typedef enum logic [1:0] {
        idle,
        writing,
        reading
    } state_t;

    state_t state;
    addr_t  base;
    addr_t  cnt;
    addr_t  addr;
    logic   last;
    logic   fetch;

    word_t  mem [n_blocks * block_size];

    assign addr      = base + cnt;
    assign last      = (cnt == addr_t'(block_size - 1));
    assign cmd_ready = (state == idle);
    assign wr_ready  = (state == writing);
    // Load the next word while nothing is on offer
    assign fetch     = (state == reading) && !rd_ready;

    // ====================
    // Control
    // ====================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            base     <= '0;
            cnt      <= '0;
            rd_ready <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cmd_trigger) begin
                        base  <= addr_t'(cmd.block) * addr_t'(block_size);
                        cnt   <= '0;
                        state <= cmd.write ? writing : reading;
                    end
                end
                writing: begin
                    if (wr_trigger) begin
                        cnt <= cnt + addr_t'(1);
                        if (last) begin
                            state <= idle;
                        end
                    end
                end
                reading: begin
                    if (!rd_ready) begin
                        rd_ready <= 1'b1;
                    end else if (rd_trigger) begin
                        rd_ready <= 1'b0;
                        cnt      <= cnt + addr_t'(1);
                        if (last) begin
                            state <= idle;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ====================
    // Block store
    // ====================

    always_ff @(posedge clk) begin
        if (wr_ready && wr_trigger) begin
            mem[addr] <= wr_data;
        end
        // Registered read, held while the consumer stalls
        if (fetch) begin
            rd_data <= mem[addr];
        end
    end

endmodule

/* verilog/pix_controller.sv */
module pix_controller #(
    parameter int block_size      = 64,
    parameter int fifo_depth_log2 = 3
) (
    input  logic              clk,
    input  logic              arst_n,

    // Command port
    input  pix_pkg::cmd_e     cmd,
    input  pix_pkg::block_t   cmd_block,
    input  logic              cmd_trigger,
    output logic              cmd_done,

    // Readout port
    output logic              readout_ready,
    input  logic              readout_trigger,
    output pix_pkg::word_t    readout_data,

    // Pixel port
    input  logic              pix_dclk,
    input  pix_pkg::pix_bus_t pix
);

    import pix_pkg::*;

    localparam int n_blocks = 2 ** $bits(block_t);

    typedef enum logic [2:0] {
        idle,
        cap_start,
        cap_cmd,
        cap_copy,
        rd_cmd,
        rd_wait
    } state_t;

    state_t   state;
    cmd_e     cmd_q;
    block_t   block_q;
    logic     cmd_pulse;
    logic     cap_toggle;

    logic     fifo_wr;
    word_t    fifo_wdata;
    logic     fifo_rd_ready;
    logic     fifo_rd_trigger;
    word_t    fifo_rd_data;

    ram_cmd_t ram_cmd;
    logic     ram_cmd_trigger;
    logic     ram_cmd_ready;
    logic     wr_trigger;
    logic     wr_ready;
    word_t    wr_data;

    // ====================
    // Pixel clock side
    // ====================

    pix_capture capture0 (
        .pix_dclk   (pix_dclk),
        .arst_n     (arst_n),
        .pix        (pix),
        .cap_toggle (cap_toggle),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata)
    );

    bank_fifo #(
        .width      ($bits(word_t)),
        .depth_log2 (fifo_depth_log2)
    ) fifo0 (
        .w_clk     (pix_dclk),
        .w_arst_n  (arst_n),
        .w_trigger (fifo_wr),
        .w_data    (fifo_wdata),
        .r_clk     (clk),
        .r_arst_n  (arst_n),
        .r_ready   (fifo_rd_ready),
        .r_trigger (fifo_rd_trigger),
        .r_data    (fifo_rd_data)
    );

    // ====================
    // Block store
    // ====================

    assign ram_cmd.block = block_q;
    assign ram_cmd.write = (cmd_q == cmd_capture);

    // Read stream goes straight to the readout port
    ram_ctrl #(
        .block_size (block_size),
        .n_blocks   (n_blocks)
    ) ram0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd         (ram_cmd),
        .cmd_trigger (ram_cmd_trigger),
        .cmd_ready   (ram_cmd_ready),
        .wr_trigger  (wr_trigger),
        .wr_data     (wr_data),
        .wr_ready    (wr_ready),
        .rd_trigger  (readout_trigger),
        .rd_ready    (readout_ready),
        .rd_data     (readout_data)
    );

    // ====================
    // Command FSM
    // ====================

    toggle_sync cmd_sync0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .toggle_in (cmd_trigger),
        .pulse     (cmd_pulse)
    );

    // Take a FIFO word when the holding register is empty or draining
    assign fifo_rd_trigger = (state == cap_copy) && (!wr_trigger || wr_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= idle;
            cmd_q           <= cmd_capture;
            block_q         <= '0;
            cmd_done        <= 1'b0;
            cap_toggle      <= 1'b0;
            ram_cmd_trigger <= 1'b0;
            wr_trigger      <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cmd_pulse) begin
                        cmd_q   <= cmd;
                        block_q <= cmd_block;
                        state   <= (cmd == cmd_capture) ? cap_start : rd_cmd;
                    end
                end
                cap_start: begin
                    cap_toggle <= ~cap_toggle;
                    state      <= cap_cmd;
                end
                // Hold the trigger until ram_ctrl takes the command
                cap_cmd: begin
                    if (ram_cmd_trigger && ram_cmd_ready) begin
                        ram_cmd_trigger <= 1'b0;
                        state           <= cap_copy;
                    end else begin
                        ram_cmd_trigger <= 1'b1;
                    end
                end
                cap_copy: begin
                    if (wr_trigger && wr_ready) begin
                        wr_trigger <= 1'b0;
                    end
                    if (fifo_rd_ready && fifo_rd_trigger) begin
                        wr_trigger <= 1'b1;
                    end
                    // ram_ctrl counts the block, so ready means the frame is in
                    if (ram_cmd_ready) begin
                        cmd_done <= ~cmd_done;
                        state    <= idle;
                    end
                end
                rd_cmd: begin
                    if (ram_cmd_trigger && ram_cmd_ready) begin
                        ram_cmd_trigger <= 1'b0;
                        state           <= rd_wait;
                    end else begin
                        ram_cmd_trigger <= 1'b1;
                    end
                end
                rd_wait: begin
                    if (ram_cmd_ready) begin
                        cmd_done <= ~cmd_done;
                        state    <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Holding register for the FIFO to block store copy
    always_ff @(posedge clk) begin
        if (fifo_rd_ready && fifo_rd_trigger) begin
            wr_data <= fifo_rd_data;
        end
    end

endmodule

/* testbench/tb_pix_controller.sv */
module tb_pix_controller;

    import pix_pkg::*;

    localparam int block_size   = 48;
    localparam int n_lines      = 6;
    localparam int n_pixels     = 8;
    localparam int front_porch  = 2;
    localparam int line_blank   = 4;
    localparam int frame_blank  = 10;
    localparam int frame_cycles = front_porch + n_lines * (n_pixels + line_blank) + frame_blank;
    localparam int hist_depth   = 16;
    localparam int n_cmds       = 7;

    // Four frames of pixel clock time per command
    localparam longint frame_time    = longint'(frame_cycles) * 230;
    localparam longint watchdog_time = 4 * frame_time * n_cmds + 2 * frame_time;

    logic     clk;
    logic     arst_n;
    cmd_e     cmd;
    block_t   cmd_block;
    logic     cmd_trigger;
    logic     cmd_done;
    logic     readout_ready;
    logic     readout_trigger;
    word_t    readout_data;
    logic     pix_dclk;
    pix_bus_t pix;

    // Sensor history, indexed by frame number
    pix_t        frame_pix [hist_depth][block_size];
    int          cur_frame;
    logic [31:0] pix_rng;
    event        mid_frame;

    // Expected contents of each block
    word_t       exp_mem [8][block_size];

    int          cmd_count;
    logic        pending;
    cmd_e        cur_cmd;
    block_t      rd_block;
    int          rd_idx;
    logic        done_q;
    logic        bp_on;
    logic [31:0] bp_state;

    pix_controller #(
        .block_size      (block_size),
        .fifo_depth_log2 (3)
    ) dut0 (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .cmd_trigger     (cmd_trigger),
        .cmd_done        (cmd_done),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .pix_dclk        (pix_dclk),
        .pix             (pix)
    );

    always #50 clk = ~clk;

    // Sensor clock, slower than clk
    always #115 pix_dclk = ~pix_dclk;

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic drive_pix(input logic fv, input logic lv, input pix_t d);
        @(posedge pix_dclk);
        #10;
        pix.fv = fv;
        pix.lv = lv;
        pix.d  = d;
    endtask

    // Toggle the command and wait for its cmd_done
    task automatic send_cmd(input cmd_e kind, input block_t block);
        @(posedge clk);
        #10;
        cmd         = kind;
        cmd_block   = block;
        cur_cmd     = kind;
        rd_block    = block;
        rd_idx      = 0;
        pending     = 1'b1;
        cmd_count++;
        cmd_trigger = ~cmd_trigger;
        wait (pending == 1'b0);
    endtask

    // Issued in the middle of a frame, so the next frame is the one stored
    task automatic capture_frame(input block_t block);
        int f;
        @(mid_frame);
        f = cur_frame + 1;
        send_cmd(cmd_capture, block);
        for (int i = 0; i < block_size; i++) begin
            exp_mem[block][i] = word_t'(frame_pix[f % hist_depth][i]);
        end
    endtask

    task automatic read_block(input block_t block, input logic with_stalls);
        bp_on = with_stalls;
        send_cmd(cmd_readout, block);
        bp_on = 1'b0;
    endtask

    // ====================
    // Sensor model
    // ====================

    // Blanking cycles carry pixel-like values that must never be stored
    initial begin : sensor
        int fno;
        fno = 0;
        wait (arst_n === 1'b1);
        forever begin
            cur_frame = fno;
            for (int i = 0; i < front_porch; i++) begin
                pix_rng = xorshift32(pix_rng);
                drive_pix(1'b1, 1'b0, pix_rng[11:0]);
            end
            for (int l = 0; l < n_lines; l++) begin
                if (l == 1) begin
                    -> mid_frame;
                end
                for (int p = 0; p < n_pixels; p++) begin
                    pix_rng = xorshift32(pix_rng);
                    frame_pix[fno % hist_depth][l * n_pixels + p] = pix_rng[11:0];
                    drive_pix(1'b1, 1'b1, pix_rng[11:0]);
                end
                for (int b = 0; b < line_blank; b++) begin
                    pix_rng = xorshift32(pix_rng);
                    drive_pix(1'b1, 1'b0, pix_rng[11:0]);
                end
            end
            for (int b = 0; b < frame_blank; b++) begin
                pix_rng = xorshift32(pix_rng);
                drive_pix(1'b0, 1'b0, pix_rng[11:0]);
            end
            fno++;
        end
    end

    // ====================
    // Readout side
    // ====================

    always begin
        @(posedge clk);
        #10;
        if (bp_on) begin
            bp_state = xorshift32(bp_state);
            readout_trigger = bp_state[7];
        end else begin
            readout_trigger = 1'b1;
        end
    end

    // Every transferred word is the next one of the block, in order
    always @(posedge clk) begin
        if (arst_n && readout_ready && readout_trigger) begin
            assert (pending && cur_cmd == cmd_readout)
                else abort_run("readout word transferred with no readout command outstanding");
            assert (rd_idx < block_size)
                else abort_run("readout returned more words than one block holds");
            assert (readout_data === exp_mem[rd_block][rd_idx])
                else abort_run($sformatf(
                    "FAIL readout_data: got 0x%04h, expected 0x%04h (block %0d, word %0d)",
                    readout_data, exp_mem[rd_block][rd_idx], rd_block, rd_idx));
            rd_idx++;
        end
    end

    // One cmd_done toggle per command, after the last word for a readout
    always @(posedge clk) begin
        if (arst_n && cmd_done !== done_q) begin
            assert (pending)
                else abort_run("cmd_done toggled with no command outstanding");
            if (cur_cmd == cmd_readout) begin
                assert (rd_idx == block_size)
                    else abort_run($sformatf(
                        "FAIL readout word count at cmd_done: got 0x%0h, expected 0x%0h",
                        rd_idx, block_size));
            end
            pending = 1'b0;
        end
        done_q = cmd_done;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        (cmd_count == 0) |-> (!cmd_done && !readout_ready))
        else abort_run($sformatf("FAIL cmd_done/readout_ready: 0x%0h/0x%0h before any command",
                                 cmd_done, readout_ready));

    // Stalled word is held
    assert property (@(posedge clk) disable iff (!arst_n)
        (readout_ready && !readout_trigger) |=> (readout_ready && $stable(readout_data)))
        else abort_run($sformatf("FAIL readout_data: 0x%04h, readout_ready 0x%0h after a stall",
                                 readout_data, readout_ready));

    initial begin
        #(watchdog_time);
        abort_run("watchdog expired before all commands completed");
    end

    // ====================
    // Main sequence
    // ====================

    initial begin
        clk             = 1'b0;
        pix_dclk        = 1'b0;
        arst_n          = 1'b0;
        cmd             = cmd_capture;
        cmd_block       = '0;
        cmd_trigger     = 1'b0;
        readout_trigger = 1'b0;
        pix             = '0;
        pix_rng         = 32'd21;
        bp_state        = 32'd21;
        bp_on           = 1'b0;
        cur_frame       = 0;
        cmd_count       = 0;
        pending         = 1'b0;
        cur_cmd         = cmd_capture;
        rd_block        = '0;
        rd_idx          = 0;
        done_q          = 1'b0;

        repeat (5) @(posedge clk);
        #10;
        arst_n = 1'b1;
        assert (cmd_done === 1'b0)
            else abort_run($sformatf("FAIL cmd_done: got 0x%0h, expected 0x0", cmd_done));
        assert (readout_ready === 1'b0)
            else abort_run($sformatf("FAIL readout_ready: got 0x%0h, expected 0x0",
                                     readout_ready));
        repeat (20) @(posedge clk);

        // Capture mid-frame, then read it back
        capture_frame(3'd0);
        read_block(3'd0, 1'b0);

        // Two blocks from different frames, read in reverse order
        capture_frame(3'd2);
        capture_frame(3'd5);
        read_block(3'd5, 1'b0);
        read_block(3'd2, 1'b1);
        read_block(3'd0, 1'b1);

        // Nothing may toggle once all commands are done
        repeat (200) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* pix_controller.f */
common/pix_pkg.sv
verilog/toggle_sync.sv
bank_fifo/bank_fifo.sv
verilog/pix_capture.sv
ram_ctrl/ram_ctrl.sv
verilog/pix_controller.sv
testbench/tb_pix_controller.sv

/* Bender.yml */
package:
  name: pix_controller

sources:
  - common/pix_pkg.sv
  - verilog/toggle_sync.sv
  - bank_fifo/bank_fifo.sv
  - verilog/pix_capture.sv
  - ram_ctrl/ram_ctrl.sv
  - verilog/pix_controller.sv
  - target: test
    files:
      - testbench/tb_pix_controller.sv
